//--- hw/cpu_types_pkg.sv
// shared word, field, encoding and latch types for the fetch and decode front end
package cpu_types_pkg;

	// basic widths fixed by the instruction set
	typedef logic [31:0] word_t;
	typedef logic [4:0]  regbits_t;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		RTYPE = 6'b000000,
		J     = 6'b000010,
		JAL   = 6'b000011,
		BEQ   = 6'b000100,
		BNE   = 6'b000101,
		ADDIU = 6'b001001,
		ANDI  = 6'b001100,
		ORI   = 6'b001101,
		LUI   = 6'b001111,
		LW    = 6'b100011,
		SW    = 6'b101011,
		HALT  = 6'b111111
	} opcode_t;

	// r-type function field, bits 5:0
	typedef enum logic [5:0] {
		JR   = 6'b001000,
		ADDU = 6'b100001,
		SUBU = 6'b100011,
		AND  = 6'b100100,
		OR   = 6'b100101,
		SLT  = 6'b101010
	} funct_t;

	// alu operation handed to execute
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_SLT = 4'd4,
		ALU_LUI = 4'd5
	} aluop_t;

	// immediate extension, zero is the all-clear value
	typedef enum logic [1:0] {
		EXT_ZERO  = 2'd0,
		EXT_SIGN  = 2'd1,
		EXT_UPPER = 2'd2
	} extop_t;

	// kind of unconditional control transfer
	typedef enum logic [1:0] {
		JSEL_NONE = 2'd0,
		JSEL_IMM  = 2'd1,
		JSEL_REG  = 2'd2
	} jumpsel_t;

	// fetch latch, instruction plus pc+4
	typedef struct packed {
		word_t imemload;
		word_t npc;
	} fetch_t;

	// decode latch, one word for the next stage
	typedef struct packed {
		regbits_t rt;
		regbits_t rw;
		aluop_t   aluctr;
		logic     alusrc;
		logic     dren;
		logic     dwen;
		logic     beq;
		logic     bne;
		jumpsel_t jumpsel;
		word_t    jumpaddr;
		logic     regwen;
		logic     memtoreg;
		logic     halt;
		word_t    npc;
		word_t    port_a;
		word_t    port_b;
		word_t    imm_ext;
	} decode_t;

endpackage

//--- hw/control_unit.sv
// combinational main decoder, opcode and function in, datapath controls out
module control_unit (
	input  cpu_types_pkg::opcode_t  opcode,
	input  cpu_types_pkg::funct_t   func,
	output cpu_types_pkg::aluop_t   aluctr,
	output logic                    alusrc,
	output logic                    regdst,
	output logic                    regwen,
	output logic                    memtoreg,
	output logic                    dren,
	output logic                    dwen,
	output logic                    beq,
	output logic                    bne,
	output logic                    jal,
	output logic                    halt,
	output cpu_types_pkg::extop_t   extop,
	output cpu_types_pkg::jumpsel_t jumpsel
);
	import cpu_types_pkg::*;

	always_comb begin
		// everything off unless an encoding below claims it
		aluctr   = ALU_ADD;
		alusrc   = 1'b0;
		regdst   = 1'b0;
		regwen   = 1'b0;
		memtoreg = 1'b0;
		dren     = 1'b0;
		dwen     = 1'b0;
		beq      = 1'b0;
		bne      = 1'b0;
		jal      = 1'b0;
		halt     = 1'b0;
		extop    = EXT_ZERO;
		jumpsel  = JSEL_NONE;
		case (opcode)
			RTYPE: begin
				// rd destination for the arithmetic group
				case (func)
					ADDU: begin
						regdst = 1'b1;
						regwen = 1'b1;
						aluctr = ALU_ADD;
					end
					SUBU: begin
						regdst = 1'b1;
						regwen = 1'b1;
						aluctr = ALU_SUB;
					end
					AND: begin
						regdst = 1'b1;
						regwen = 1'b1;
						aluctr = ALU_AND;
					end
					OR: begin
						regdst = 1'b1;
						regwen = 1'b1;
						aluctr = ALU_OR;
					end
					SLT: begin
						regdst = 1'b1;
						regwen = 1'b1;
						aluctr = ALU_SLT;
					end
					// jump through rs, nothing written back
					JR: jumpsel = JSEL_REG;
					default: ;
				endcase
			end
			ADDIU: begin
				alusrc = 1'b1;
				regwen = 1'b1;
				extop  = EXT_SIGN;
			end
			ANDI: begin
				alusrc = 1'b1;
				regwen = 1'b1;
				aluctr = ALU_AND;
			end
			ORI: begin
				alusrc = 1'b1;
				regwen = 1'b1;
				aluctr = ALU_OR;
			end
			LUI: begin
				alusrc = 1'b1;
				regwen = 1'b1;
				aluctr = ALU_LUI;
				extop  = EXT_UPPER;
			end
			LW: begin
				// address is base plus signed offset
				alusrc   = 1'b1;
				regwen   = 1'b1;
				memtoreg = 1'b1;
				dren     = 1'b1;
				extop    = EXT_SIGN;
			end
			SW: begin
				alusrc = 1'b1;
				dwen   = 1'b1;
				extop  = EXT_SIGN;
			end
			// branch offsets are signed word counts
			BEQ: begin
				beq    = 1'b1;
				aluctr = ALU_SUB;
				extop  = EXT_SIGN;
			end
			BNE: begin
				bne    = 1'b1;
				aluctr = ALU_SUB;
				extop  = EXT_SIGN;
			end
			J: jumpsel = JSEL_IMM;
			JAL: begin
				// link lands in r31
				jumpsel = JSEL_IMM;
				jal     = 1'b1;
				regwen  = 1'b1;
			end
			HALT: halt = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- hw/register_file.sv
// 32 x 32 register file, two combinational reads, one clocked write, r0 fixed at zero
module register_file (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   wen,
	input  cpu_types_pkg::regbits_t wsel,
	input  cpu_types_pkg::regbits_t rsel1,
	input  cpu_types_pkg::regbits_t rsel2,
	input  cpu_types_pkg::word_t   wdat,
	output cpu_types_pkg::word_t   rdat1,
	output cpu_types_pkg::word_t   rdat2
);
	import cpu_types_pkg::*;

	word_t regs [32];

	// entry 0 is cleared by reset and never written after
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (wsel != '0)) begin
			regs[wsel] <= wdat;
		end
	end

	// no bypass, new value visible the cycle after the write
	assign rdat1 = regs[rsel1];
	assign rdat2 = regs[rsel2];

endmodule

//--- hw/fetch_stage.sv
// program counter and fetch latch, drives the instruction memory address
module fetch_stage (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  ihit,
	input  logic                  freeze,
	input  logic                  redirect,
	input  logic                  flush,
	input  cpu_types_pkg::word_t  target,
	input  cpu_types_pkg::word_t  imemload,
	output cpu_types_pkg::word_t  imem_addr,
	output cpu_types_pkg::fetch_t fetch_p
);
	import cpu_types_pkg::*;

	word_t pc;
	word_t pc_plus4;
	word_t pc_next;
	logic  advance;

	// move only when memory answered and nothing downstream holds
	assign advance  = ihit && !freeze;
	assign pc_plus4 = pc + 32'd4;
	assign pc_next  = redirect ? target : pc_plus4;

	assign imem_addr = pc;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= '0;
		end else if (advance) begin
			pc <= pc_next;
		end
	end

	// taken redirect squashes the sequential fetch into a no-op
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			fetch_p <= '0;
		end else if (advance) begin
			if (flush) begin
				fetch_p <= '0;
			end else begin
				fetch_p.imemload <= imemload;
				fetch_p.npc      <= pc_plus4;
			end
		end
	end

endmodule

//--- hw/decode_stage.sv
// decode stage, splits the fetched word, reads registers and fills the decode latch
module decode_stage (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    ihit,
	input  logic                    freeze,
	input  logic                    flush_d,
	input  cpu_types_pkg::fetch_t   fetch_p,
	input  logic                    wb_wen,
	input  cpu_types_pkg::regbits_t wb_sel,
	input  cpu_types_pkg::word_t    wb_dat,
	output cpu_types_pkg::decode_t  decode_p,
	output logic                    beq,
	output logic                    bne,
	output logic                    equal,
	output cpu_types_pkg::jumpsel_t jumpsel,
	output cpu_types_pkg::word_t    npc,
	output cpu_types_pkg::word_t    imm_ext,
	output cpu_types_pkg::word_t    jumpaddr,
	output cpu_types_pkg::word_t    port_a
);
	import cpu_types_pkg::*;

	word_t       instr;
	opcode_t     op;
	regbits_t    rs;
	regbits_t    rt;
	regbits_t    rd;
	logic [15:0] imm;
	funct_t      func;

	aluop_t   aluctr;
	logic     alusrc;
	logic     regdst;
	logic     regwen;
	logic     memtoreg;
	logic     dren;
	logic     dwen;
	logic     jal;
	logic     halt;
	extop_t   extop;
	word_t    rdat1;
	word_t    rdat2;
	regbits_t rw;
	decode_t  decode_n;

	// instruction fields
	assign instr = fetch_p.imemload;
	assign op    = opcode_t'(instr[31:26]);
	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];
	assign imm   = instr[15:0];
	assign func  = funct_t'(instr[5:0]);

	control_unit cu (
		.opcode(op), .func(func), .aluctr(aluctr), .alusrc(alusrc),
		.regdst(regdst), .regwen(regwen), .memtoreg(memtoreg),
		.dren(dren), .dwen(dwen), .beq(beq), .bne(bne), .jal(jal),
		.halt(halt), .extop(extop), .jumpsel(jumpsel)
	);

	// writeback port comes straight from outside
	register_file rf (
		.CLK(CLK), .nRST(nRST), .wen(wb_wen), .wsel(wb_sel),
		.rsel1(rs), .rsel2(rt), .wdat(wb_dat),
		.rdat1(rdat1), .rdat2(rdat2)
	);

	always_comb begin
		case (extop)
			EXT_SIGN:  imm_ext = {{16{imm[15]}}, imm};
			EXT_UPPER: imm_ext = {imm, 16'h0000};
			default:   imm_ext = {16'h0000, imm};
		endcase
	end

	// link register wins over rd
	assign rw = jal ? 5'd31 : (regdst ? rd : rt);

	// values the hazard unit resolves in this stage
	assign npc      = fetch_p.npc;
	assign jumpaddr = {fetch_p.npc[31:28], instr[25:0], 2'b00};
	assign port_a   = rdat1;
	assign equal    = (rdat1 == rdat2);

	always_comb begin
		decode_n.rt       = rt;
		decode_n.rw       = rw;
		decode_n.aluctr   = aluctr;
		decode_n.alusrc   = alusrc;
		decode_n.dren     = dren;
		decode_n.dwen     = dwen;
		decode_n.beq      = beq;
		decode_n.bne      = bne;
		decode_n.jumpsel  = jumpsel;
		decode_n.jumpaddr = jumpaddr;
		decode_n.regwen   = regwen;
		decode_n.memtoreg = memtoreg;
		decode_n.halt     = halt;
		decode_n.npc      = npc;
		decode_n.port_a   = rdat1;
		decode_n.port_b   = rdat2;
		decode_n.imm_ext  = imm_ext;
	end

	// flush wins, then hold on freeze or missing ihit
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			decode_p <= '0;
		end else if (flush_d) begin
			decode_p <= '0;
		end else if (ihit && !freeze) begin
			decode_p <= decode_n;
		end
	end

endmodule

//--- hw/hazard_unit.sv
// control-flow resolver in decode, picks the redirect target and squashes fetch
module hazard_unit (
	input  logic                    ihit,
	input  logic                    freeze,
	input  logic                    beq,
	input  logic                    bne,
	input  logic                    equal,
	input  cpu_types_pkg::jumpsel_t jumpsel,
	input  cpu_types_pkg::word_t    npc,
	input  cpu_types_pkg::word_t    imm_ext,
	input  cpu_types_pkg::word_t    jumpaddr,
	input  cpu_types_pkg::word_t    port_a,
	output logic                    redirect,
	output logic                    flush,
	output cpu_types_pkg::word_t    target
);
	import cpu_types_pkg::*;

	logic taken;

	assign taken = (beq && equal) || (bne && !equal) || (jumpsel != JSEL_NONE);

	always_comb begin
		case (jumpsel)
			JSEL_IMM: target = jumpaddr;
			JSEL_REG: target = port_a;
			// branch offset counts words from pc+4
			default:  target = npc + {imm_ext[29:0], 2'b00};
		endcase
	end

	// only acts on an edge where the pipe actually moves
	assign redirect = taken && ihit && !freeze;
	assign flush    = redirect;

endmodule

//--- hw/cpu_decode_core.sv
// front-end top level, fetch, decode and branch resolution wired to memory and writeback ports
module cpu_decode_core (
	input  logic                    CLK,
	input  logic                    nRST,
	output cpu_types_pkg::word_t    imem_addr,
	input  cpu_types_pkg::word_t    imemload,
	input  logic                    ihit,
	input  logic                    freeze,
	input  logic                    wb_wen,
	input  cpu_types_pkg::regbits_t wb_sel,
	input  cpu_types_pkg::word_t    wb_dat,
	output cpu_types_pkg::decode_t  decode_p
);
	import cpu_types_pkg::*;

	fetch_t   fetch_p;
	logic     redirect;
	logic     flush;
	word_t    target;
	logic     beq;
	logic     bne;
	logic     equal;
	jumpsel_t jumpsel;
	word_t    npc;
	word_t    imm_ext;
	word_t    jumpaddr;
	word_t    port_a;

	fetch_stage fetch (
		.CLK(CLK), .nRST(nRST), .ihit(ihit), .freeze(freeze),
		.redirect(redirect), .flush(flush), .target(target),
		.imemload(imemload), .imem_addr(imem_addr), .fetch_p(fetch_p)
	);

	// no execute stage yet, so nothing flushes the decode latch
	decode_stage decode (
		.CLK(CLK), .nRST(nRST), .ihit(ihit), .freeze(freeze),
		.flush_d(1'b0), .fetch_p(fetch_p),
		.wb_wen(wb_wen), .wb_sel(wb_sel), .wb_dat(wb_dat),
		.decode_p(decode_p),
		.beq(beq), .bne(bne), .equal(equal), .jumpsel(jumpsel),
		.npc(npc), .imm_ext(imm_ext), .jumpaddr(jumpaddr), .port_a(port_a)
	);

	hazard_unit hazard (
		.ihit(ihit), .freeze(freeze),
		.beq(beq), .bne(bne), .equal(equal), .jumpsel(jumpsel),
		.npc(npc), .imm_ext(imm_ext), .jumpaddr(jumpaddr), .port_a(port_a),
		.redirect(redirect), .flush(flush), .target(target)
	);

endmodule

//--- tests/tb_cpu_decode_core.sv
// simulation top that runs a directed program and a random mix through cpu_decode_core against a model
module tb_cpu_decode_core;
	import cpu_types_pkg::*;

	localparam int RESET_CYCLES    = 3;
	localparam int PRELOAD_CYCLES  = 10;
	localparam int DIRECTED_CYCLES = 60;
	localparam int RANDOM_CYCLES   = 400;
	localparam int CYCLE_LIMIT =
		4 * (RESET_CYCLES + PRELOAD_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 4);

	logic     CLK = 1'b0;
	logic     nRST;
	word_t    imem_addr;
	word_t    imemload = '0;
	logic     ihit;
	logic     freeze;
	logic     wb_wen;
	regbits_t wb_sel;
	word_t    wb_dat;
	decode_t  decode_p;

	word_t       imem [256];
	logic [31:0] rng;
	string       test_name;
	logic        started = 1'b0;
	int unsigned cycles = 0;

	// model state
	word_t   exp_pc;
	word_t   exp_fetch_instr;
	word_t   exp_fetch_npc;
	decode_t exp_dec;
	word_t   exp_regs [32];
	decode_t next_dec;
	logic    taken;
	word_t   next_target;

	cpu_decode_core cpu_decode_core_i (
		.CLK(CLK), .nRST(nRST), .imem_addr(imem_addr), .imemload(imemload),
		.ihit(ihit), .freeze(freeze), .wb_wen(wb_wen), .wb_sel(wb_sel),
		.wb_dat(wb_dat), .decode_p(decode_p)
	);

	always #20 CLK = ~CLK;

	// memory answers on the falling edge and wraps at 1 KiB
	always @(negedge CLK) imemload = imem[imem_addr[9:2]];

	always @(posedge CLK) started <= 1'b1;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t encode_r(input funct_t f, input regbits_t rd,
		input regbits_t rs, input regbits_t rt);
		return {RTYPE, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic word_t encode_i(input opcode_t op, input regbits_t rt,
		input regbits_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encode_j(input opcode_t op, input logic [25:0] tgt);
		return {op, tgt};
	endfunction

	// any supported instruction with operand fields straight from the random word
	function automatic word_t random_instr(input logic [31:0] r);
		word_t w;
		w = r;
		case (r[31:28])
			4'd0, 4'd1, 4'd2: begin
				w[31:26] = RTYPE;
				case (r[2:0])
					3'd0: w[5:0] = ADDU;
					3'd1: w[5:0] = SUBU;
					3'd2: w[5:0] = AND;
					3'd3: w[5:0] = OR;
					default: w[5:0] = SLT;
				endcase
			end
			4'd3: begin
				w[31:26] = RTYPE;
				w[5:0]   = JR;
			end
			4'd4: w[31:26] = ADDIU;
			4'd5: w[31:26] = ANDI;
			4'd6: w[31:26] = ORI;
			4'd7: w[31:26] = LUI;
			4'd8: w[31:26] = LW;
			4'd9: w[31:26] = SW;
			4'd10: w[31:26] = BEQ;
			4'd11: w[31:26] = BNE;
			4'd12: w[31:26] = J;
			4'd13: w[31:26] = JAL;
			4'd14: w[31:26] = HALT;
			default: w[31:26] = ADDIU;
		endcase
		return w;
	endfunction

	// decode rules applied to the model's fetch latch and register copy
	function automatic decode_t expect_decode(input word_t ins, input word_t npc);
		decode_t     d;
		logic [15:0] imm;
		logic        link;
		logic        rd_dst;
		extop_t      ext;
		d      = '0;
		imm    = ins[15:0];
		link   = 1'b0;
		rd_dst = 1'b0;
		ext    = EXT_ZERO;
		case (ins[31:26])
			RTYPE: begin
				case (ins[5:0])
					ADDU: d.aluctr = ALU_ADD;
					SUBU: d.aluctr = ALU_SUB;
					AND: d.aluctr = ALU_AND;
					OR: d.aluctr = ALU_OR;
					SLT: d.aluctr = ALU_SLT;
					JR: d.jumpsel = JSEL_REG;
					default: ;
				endcase
				rd_dst   = ins[5:0] inside {ADDU, SUBU, AND, OR, SLT};
				d.regwen = rd_dst;
			end
			ADDIU: begin
				d.alusrc = 1'b1;
				d.regwen = 1'b1;
				ext      = EXT_SIGN;
			end
			ANDI: begin
				d.alusrc = 1'b1;
				d.regwen = 1'b1;
				d.aluctr = ALU_AND;
			end
			ORI: begin
				d.alusrc = 1'b1;
				d.regwen = 1'b1;
				d.aluctr = ALU_OR;
			end
			LUI: begin
				d.alusrc = 1'b1;
				d.regwen = 1'b1;
				d.aluctr = ALU_LUI;
				ext      = EXT_UPPER;
			end
			LW: begin
				d.alusrc   = 1'b1;
				d.regwen   = 1'b1;
				d.memtoreg = 1'b1;
				d.dren     = 1'b1;
				ext        = EXT_SIGN;
			end
			SW: begin
				d.alusrc = 1'b1;
				d.dwen   = 1'b1;
				ext      = EXT_SIGN;
			end
			BEQ: begin
				d.beq    = 1'b1;
				d.aluctr = ALU_SUB;
				ext      = EXT_SIGN;
			end
			BNE: begin
				d.bne    = 1'b1;
				d.aluctr = ALU_SUB;
				ext      = EXT_SIGN;
			end
			J: d.jumpsel = JSEL_IMM;
			JAL: begin
				d.jumpsel = JSEL_IMM;
				d.regwen  = 1'b1;
				link      = 1'b1;
			end
			HALT: d.halt = 1'b1;
			default: ;
		endcase
		case (ext)
			EXT_SIGN: d.imm_ext = {{16{imm[15]}}, imm};
			EXT_UPPER: d.imm_ext = {imm, 16'h0000};
			default: d.imm_ext = {16'h0000, imm};
		endcase
		d.rt       = ins[20:16];
		d.rw       = link ? 5'd31 : (rd_dst ? ins[15:11] : ins[20:16]);
		d.jumpaddr = {npc[31:28], ins[25:0], 2'b00};
		d.npc      = npc;
		d.port_a   = exp_regs[ins[25:21]];
		d.port_b   = exp_regs[ins[20:16]];
		return d;
	endfunction

	// model steps on the same edges as the DUT
	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			exp_pc          <= '0;
			exp_fetch_instr <= '0;
			exp_fetch_npc   <= '0;
			exp_dec         <= '0;
			for (int i = 0; i < 32; i++) begin
				exp_regs[i] <= '0;
			end
		end else begin
			if (ihit && !freeze) begin
				next_dec = expect_decode(exp_fetch_instr, exp_fetch_npc);
				taken = (next_dec.beq && (next_dec.port_a == next_dec.port_b))
					|| (next_dec.bne && (next_dec.port_a != next_dec.port_b))
					|| (next_dec.jumpsel != JSEL_NONE);
				if (next_dec.jumpsel == JSEL_IMM)
					next_target = next_dec.jumpaddr;
				else if (next_dec.jumpsel == JSEL_REG)
					next_target = next_dec.port_a;
				else
					next_target = next_dec.npc + (next_dec.imm_ext << 2);
				exp_dec <= next_dec;
				if (taken) begin
					// fetched word is squashed
					exp_pc          <= next_target;
					exp_fetch_instr <= '0;
					exp_fetch_npc   <= '0;
				end else begin
					exp_pc          <= exp_pc + 32'd4;
					exp_fetch_instr <= imemload;
					exp_fetch_npc   <= exp_pc + 32'd4;
				end
			end
			if (wb_wen && (wb_sel != '0))
				exp_regs[wb_sel] <= wb_dat;
		end
	end

	task automatic fail_value(input string what, input logic [183:0] expected,
		input logic [183:0] actual);
		$display("** Error [%s] %s expected %h actual %h", test_name, what, expected, actual);
		$display("RESULT: FAIL");
		$fatal(1, "mismatch against the model");
	endtask

	a_decode: assert property (@(posedge CLK) started |-> decode_p === exp_dec)
		else fail_value("decode_p", $sampled(exp_dec), $sampled(decode_p));

	a_pc: assert property (@(posedge CLK) started |-> imem_addr === exp_pc)
		else fail_value("imem_addr", $sampled(exp_pc), $sampled(imem_addr));

	// both outputs cleared while reset is held
	a_reset_addr: assert property (@(posedge CLK) started && !nRST |-> imem_addr === '0)
		else fail_value("imem_addr in reset", '0, $sampled(imem_addr));

	a_reset_dec: assert property (@(posedge CLK) started && !nRST |-> decode_p === '0)
		else fail_value("decode_p in reset", '0, $sampled(decode_p));

	// held registers must not move
	a_hold: assert property (@(posedge CLK)
		started && (!ihit || freeze) |=> $stable(imem_addr) && $stable(decode_p))
		else begin
			$display("[%s] imem_addr or decode_p changed during a stall", test_name);
			$display("RESULT: FAIL");
			$fatal(1, "stall not held");
		end

	task automatic write_reg(input regbits_t sel, input word_t dat);
		@(negedge CLK);
		wb_wen = 1'b1;
		wb_sel = sel;
		wb_dat = dat;
	endtask

	// directed program whose squashed slots keep random words
	task automatic load_program();
		imem[0]  = encode_r(ADDU, 5'd10, 5'd1, 5'd4);
		imem[1]  = encode_r(SUBU, 5'd11, 5'd3, 5'd1);
		imem[2]  = encode_r(SLT, 5'd12, 5'd3, 5'd1);
		imem[3]  = encode_r(OR, 5'd13, 5'd0, 5'd4);
		imem[4]  = encode_i(ADDIU, 5'd14, 5'd1, 16'hfff0);
		imem[5]  = encode_i(ORI, 5'd15, 5'd1, 16'h8001);
		imem[6]  = encode_i(LUI, 5'd16, 5'd0, 16'hbeef);
		imem[7]  = encode_i(LW, 5'd17, 5'd2, 16'd8);
		imem[8]  = encode_i(SW, 5'd4, 5'd2, 16'hfffc);
		imem[9]  = encode_j(J, 26'd12);
		imem[12] = encode_j(JAL, 26'd15);
		imem[15] = encode_r(JR, 5'd0, 5'd6, 5'd0);
		// equal operands take the branch to word 23
		imem[20] = encode_i(BEQ, 5'd2, 5'd1, 16'd2);
		imem[23] = encode_i(BEQ, 5'd3, 5'd1, 16'd2);
		imem[24] = encode_i(BNE, 5'd2, 5'd1, 16'd3);
		// unequal operands take the branch to word 28
		imem[25] = encode_i(BNE, 5'd3, 5'd1, 16'd2);
		imem[28] = encode_r(ADDU, 5'd10, 5'd7, 5'd7);
		imem[29] = {HALT, 26'd0};
	endtask

	initial begin
		int step;
		test_name = "reset";
		nRST   = 1'b0;
		freeze = 1'b1;
		ihit   = 1'b1;
		wb_wen = 1'b0;
		wb_sel = '0;
		wb_dat = '0;
		rng    = 32'd71;
		for (int i = 0; i < 256; i++) begin
			rng     = xorshift(rng);
			imem[i] = random_instr(rng);
		end
		load_program();
		repeat (RESET_CYCLES) @(negedge CLK);
		nRST = 1'b1;

		// pipe frozen while registers are loaded
		test_name = "preload";
		write_reg(5'd1, 32'd5);
		write_reg(5'd2, 32'd5);
		write_reg(5'd3, 32'hfffffffd);
		write_reg(5'd4, 32'h00001234);
		write_reg(5'd6, 32'h00000050);
		write_reg(5'd7, 32'd7);
		write_reg(5'd0, 32'h0000dead);
		@(negedge CLK);
		wb_wen = 1'b0;

		test_name = "directed";
		freeze = 1'b0;
		step = 0;
		while (!decode_p.halt) begin
			@(negedge CLK);
			step++;
			// short freeze every seventh cycle
			freeze = ((step % 7) == 5);
		end

		// random ihit drops, freezes and writebacks
		test_name = "random";
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			@(negedge CLK);
			rng    = xorshift(rng);
			ihit   = (rng[1:0] != 2'b00);
			freeze = (rng[4:2] == 3'b000);
			wb_wen = rng[5];
			wb_sel = rng[10:6];
			rng    = xorshift(rng);
			wb_dat = rng;
		end
		@(negedge CLK);
		wb_wen = 1'b0;
		repeat (2) @(negedge CLK);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- cpu_decode.f
hw/cpu_types_pkg.sv
hw/control_unit.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/cpu_decode_core.sv
tests/tb_cpu_decode_core.sv

//--- Bender.yml
package:
  name: cpu_decode

sources:
  - hw/cpu_types_pkg.sv
  - hw/control_unit.sv
  - hw/register_file.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/hazard_unit.sv
  - hw/cpu_decode_core.sv
  - target: test
    files:
      - tests/tb_cpu_decode_core.sv
